// ==== source/region_pkg.sv ====
// widths, region tag, data RAM sizes, interrupt sizes and the response-source enum
`default_nettype none

package region_pkg;

  // LSU and external bus
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // local data RAM
  localparam int unsigned RAM_BYTES  = 32768;
  localparam int unsigned RAM_WORDS  = RAM_BYTES / BE_W;
  localparam int unsigned RAM_ADDR_W = $clog2(RAM_WORDS);

  // host port addresses bytes inside the RAM
  localparam int unsigned APB_ADDR_W = $clog2(RAM_BYTES);

  // upper address bits that select the local RAM
  localparam logic [11:0] REGION_TAG     = 12'h001;
  localparam int unsigned REGION_TAG_LSB = 20;

  // interrupt lines
  localparam int unsigned IRQ_N    = 32;
  localparam int unsigned IRQ_ID_W = $clog2(IRQ_N);

  // target whose response is due next
  typedef enum logic [0:0] {
    RESP_RAM = 1'b0,
    RESP_EXT = 1'b1
  } resp_src_t;

endpackage

`default_nettype wire

// ==== source/lsu_router.sv ====
// LSU address decode, grant steering and response-source FSM
`default_nettype none

module lsu_router (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  // core LSU port
  input  wire logic                              lsu_req_i,
  input  wire logic [region_pkg::ADDR_W-1:0]     lsu_addr_i,
  input  wire logic                              lsu_we_i,
  input  wire logic [region_pkg::BE_W-1:0]       lsu_be_i,
  input  wire logic [region_pkg::DATA_W-1:0]     lsu_wdata_i,
  output logic                                   lsu_gnt_o,
  output logic                                   lsu_rvalid_o,
  output logic [region_pkg::DATA_W-1:0]          lsu_rdata_o,
  // external port
  output logic                                   ext_req_o,
  output logic [region_pkg::ADDR_W-1:0]          ext_addr_o,
  output logic                                   ext_we_o,
  output logic [region_pkg::BE_W-1:0]            ext_be_o,
  output logic [region_pkg::DATA_W-1:0]          ext_wdata_o,
  input  wire logic                              ext_gnt_i,
  input  wire logic                              ext_rvalid_i,
  input  wire logic [region_pkg::DATA_W-1:0]     ext_rdata_i,
  // local RAM path
  output logic                                   ram_req_o,
  output logic [region_pkg::RAM_ADDR_W-1:0]      ram_addr_o,
  output logic                                   ram_we_o,
  output logic [region_pkg::BE_W-1:0]            ram_be_o,
  output logic [region_pkg::DATA_W-1:0]          ram_wdata_o,
  input  wire logic                              ram_gnt_i,
  input  wire logic                              ram_rvalid_i,
  input  wire logic [region_pkg::DATA_W-1:0]     ram_rdata_i
);

  logic                  is_local;
  region_pkg::resp_src_t resp_q;
  region_pkg::resp_src_t resp_d;

  // tag compare on the upper twelve address bits
  assign is_local = (lsu_addr_i[region_pkg::REGION_TAG_LSB +: 12] == region_pkg::REGION_TAG);

  assign ram_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // byte offset dropped for the RAM word address
  assign ram_addr_o  = lsu_addr_i[region_pkg::RAM_ADDR_W+1:2];
  assign ram_we_o    = lsu_we_i;
  assign ram_be_o    = lsu_be_i;
  assign ram_wdata_o = lsu_wdata_i;

  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  // grant comes from whichever target was addressed
  always_comb begin
    lsu_gnt_o = 1'b0;
    resp_d    = resp_q;
    if (ext_req_o) begin
      lsu_gnt_o = ext_gnt_i;
      if (ext_gnt_i) begin
        resp_d = region_pkg::RESP_EXT;
      end
    end else if (ram_req_o) begin
      lsu_gnt_o = ram_gnt_i;
      if (ram_gnt_i) begin
        resp_d = region_pkg::RESP_RAM;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_q <= region_pkg::RESP_RAM;
    end else begin
      resp_q <= resp_d;
    end
  end

  // the last grant names the source of the single outstanding response
  assign lsu_rdata_o  = (resp_q == region_pkg::RESP_EXT) ? ext_rdata_i : ram_rdata_i;
  assign lsu_rvalid_o = ext_rvalid_i | ram_rvalid_i;

endmodule

`default_nettype wire

// ==== source/data_ram_arbiter.sv ====
// host-priority arbiter of the core and host ports onto one RAM port
`default_nettype none

module data_ram_arbiter (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  // core side
  input  wire logic                              core_req_i,
  input  wire logic [region_pkg::RAM_ADDR_W-1:0] core_addr_i,
  input  wire logic                              core_we_i,
  input  wire logic [region_pkg::BE_W-1:0]       core_be_i,
  input  wire logic [region_pkg::DATA_W-1:0]     core_wdata_i,
  output logic                                   core_gnt_o,
  output logic                                   core_rvalid_o,
  output logic [region_pkg::DATA_W-1:0]          core_rdata_o,
  // host side
  input  wire logic                              host_req_i,
  input  wire logic [region_pkg::RAM_ADDR_W-1:0] host_addr_i,
  input  wire logic                              host_we_i,
  input  wire logic [region_pkg::BE_W-1:0]       host_be_i,
  input  wire logic [region_pkg::DATA_W-1:0]     host_wdata_i,
  output logic [region_pkg::DATA_W-1:0]          host_rdata_o,
  // RAM side
  output logic                                   mem_en_o,
  output logic [region_pkg::RAM_ADDR_W-1:0]      mem_addr_o,
  output logic                                   mem_we_o,
  output logic [region_pkg::BE_W-1:0]            mem_be_o,
  output logic [region_pkg::DATA_W-1:0]          mem_wdata_o,
  input  wire logic [region_pkg::DATA_W-1:0]     mem_rdata_i
);

  logic core_gnt_q;

  // host always wins and the core waits for a free cycle
  assign core_gnt_o = core_req_i & ~host_req_i;
  assign mem_en_o   = core_req_i | host_req_i;

  always_comb begin
    if (host_req_i) begin
      mem_addr_o  = host_addr_i;
      mem_we_o    = host_we_i;
      mem_be_o    = host_be_i;
      mem_wdata_o = host_wdata_i;
    end else begin
      mem_addr_o  = core_addr_i;
      mem_we_o    = core_we_i;
      mem_be_o    = core_be_i;
      mem_wdata_o = core_wdata_i;
    end
  end

  // RAM answers one cycle after the grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_gnt_q <= 1'b0;
    end else begin
      core_gnt_q <= core_gnt_o;
    end
  end

  assign core_rvalid_o = core_gnt_q;

  // read data fanned out to both ports
  assign core_rdata_o = mem_rdata_i;
  assign host_rdata_o = mem_rdata_i;

endmodule

`default_nettype wire

// ==== source/sp_data_ram.sv ====
// single-port byte-enabled RAM with registered read data
`default_nettype none

module sp_data_ram #(
  parameter int unsigned DEPTH = region_pkg::RAM_WORDS
) (
  input  wire logic                              clk,
  input  wire logic                              en_i,
  input  wire logic [region_pkg::RAM_ADDR_W-1:0] addr_i,
  input  wire logic                              we_i,
  input  wire logic [region_pkg::BE_W-1:0]       be_i,
  input  wire logic [region_pkg::DATA_W-1:0]     wdata_i,
  output logic [region_pkg::DATA_W-1:0]          rdata_o
);

  logic [region_pkg::DATA_W-1:0] mem [DEPTH];

  // byte lanes written independently
  always_ff @(posedge clk) begin
    if (en_i && we_i) begin
      for (int b = 0; b < region_pkg::BE_W; b++) begin
        if (be_i[b]) begin
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read port holds its value until the next read
  always_ff @(posedge clk) begin
    if (en_i && !we_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== source/apb_mem_port.sv ====
// APB slave issuing one RAM request per transfer with one wait state
`default_nettype none

module apb_mem_port (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  // APB slave
  input  wire logic                              psel_i,
  input  wire logic                              penable_i,
  input  wire logic                              pwrite_i,
  input  wire logic [region_pkg::APB_ADDR_W-1:0] paddr_i,
  input  wire logic [region_pkg::DATA_W-1:0]     pwdata_i,
  input  wire logic [region_pkg::BE_W-1:0]       pstrb_i,
  output logic [region_pkg::DATA_W-1:0]          prdata_o,
  output logic                                   pready_o,
  // RAM request side
  output logic                                   mem_req_o,
  output logic [region_pkg::RAM_ADDR_W-1:0]      mem_addr_o,
  output logic                                   mem_we_o,
  output logic [region_pkg::BE_W-1:0]            mem_be_o,
  output logic [region_pkg::DATA_W-1:0]          mem_wdata_o,
  input  wire logic [region_pkg::DATA_W-1:0]     mem_rdata_i
);

  // high in the second access cycle of a transfer
  logic ready_q;

  // request in the first access cycle only, served at once by the arbiter
  assign mem_req_o = psel_i & penable_i & ~ready_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= mem_req_o;
    end
  end

  assign pready_o = ready_q;

  // byte offset dropped for the word address
  assign mem_addr_o  = paddr_i[region_pkg::APB_ADDR_W-1:2];
  assign mem_we_o    = pwrite_i;
  assign mem_be_o    = pstrb_i;
  assign mem_wdata_o = pwdata_i;

  // registered RAM output is valid in the ready cycle
  assign prdata_o = mem_rdata_i;

endmodule

`default_nettype wire

// ==== source/irq_encoder.sv ====
// any-interrupt flag and index of the highest set line
`default_nettype none

module irq_encoder (
  input  wire logic [region_pkg::IRQ_N-1:0]    irq_i,
  output logic                                 irq_o,
  output logic [region_pkg::IRQ_ID_W-1:0]      irq_id_o
);

  assign irq_o = |irq_i;

  // later lines overwrite earlier ones and the highest wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < region_pkg::IRQ_N; i++) begin
      if (irq_i[i]) begin
        irq_id_o = region_pkg::IRQ_ID_W'(i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/core_region.sv ====
// top level joining the LSU router, RAM arbiter, data RAM, APB port and irq encoder
`default_nettype none

module core_region (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  // core LSU port
  input  wire logic                              lsu_req_i,
  input  wire logic [region_pkg::ADDR_W-1:0]     lsu_addr_i,
  input  wire logic                              lsu_we_i,
  input  wire logic [region_pkg::BE_W-1:0]       lsu_be_i,
  input  wire logic [region_pkg::DATA_W-1:0]     lsu_wdata_i,
  output logic                                   lsu_gnt_o,
  output logic                                   lsu_rvalid_o,
  output logic [region_pkg::DATA_W-1:0]          lsu_rdata_o,
  // external port
  output logic                                   ext_req_o,
  output logic [region_pkg::ADDR_W-1:0]          ext_addr_o,
  output logic                                   ext_we_o,
  output logic [region_pkg::BE_W-1:0]            ext_be_o,
  output logic [region_pkg::DATA_W-1:0]          ext_wdata_o,
  input  wire logic                              ext_gnt_i,
  input  wire logic                              ext_rvalid_i,
  input  wire logic [region_pkg::DATA_W-1:0]     ext_rdata_i,
  // APB host port into the data RAM
  input  wire logic                              psel_i,
  input  wire logic                              penable_i,
  input  wire logic                              pwrite_i,
  input  wire logic [region_pkg::APB_ADDR_W-1:0] paddr_i,
  input  wire logic [region_pkg::DATA_W-1:0]     pwdata_i,
  input  wire logic [region_pkg::BE_W-1:0]       pstrb_i,
  output logic [region_pkg::DATA_W-1:0]          prdata_o,
  output logic                                   pready_o,
  // interrupts
  input  wire logic [region_pkg::IRQ_N-1:0]      irq_i,
  output logic                                   irq_o,
  output logic [region_pkg::IRQ_ID_W-1:0]        irq_id_o
);

  // router to arbiter
  logic                              ram_req;
  logic [region_pkg::RAM_ADDR_W-1:0] ram_addr;
  logic                              ram_we;
  logic [region_pkg::BE_W-1:0]       ram_be;
  logic [region_pkg::DATA_W-1:0]     ram_wdata;
  logic                              ram_gnt;
  logic                              ram_rvalid;
  logic [region_pkg::DATA_W-1:0]     ram_rdata;

  // APB port to arbiter
  logic                              host_req;
  logic [region_pkg::RAM_ADDR_W-1:0] host_addr;
  logic                              host_we;
  logic [region_pkg::BE_W-1:0]       host_be;
  logic [region_pkg::DATA_W-1:0]     host_wdata;
  logic [region_pkg::DATA_W-1:0]     host_rdata;

  // arbiter to RAM
  logic                              mem_en;
  logic [region_pkg::RAM_ADDR_W-1:0] mem_addr;
  logic                              mem_we;
  logic [region_pkg::BE_W-1:0]       mem_be;
  logic [region_pkg::DATA_W-1:0]     mem_wdata;
  logic [region_pkg::DATA_W-1:0]     mem_rdata;

  lsu_router u_lsu_router (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req_i),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_we_i     (lsu_we_i),
    .lsu_be_i     (lsu_be_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .lsu_gnt_o    (lsu_gnt_o),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .ext_req_o    (ext_req_o),
    .ext_addr_o   (ext_addr_o),
    .ext_we_o     (ext_we_o),
    .ext_be_o     (ext_be_o),
    .ext_wdata_o  (ext_wdata_o),
    .ext_gnt_i    (ext_gnt_i),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i),
    .ram_req_o    (ram_req),
    .ram_addr_o   (ram_addr),
    .ram_we_o     (ram_we),
    .ram_be_o     (ram_be),
    .ram_wdata_o  (ram_wdata),
    .ram_gnt_i    (ram_gnt),
    .ram_rvalid_i (ram_rvalid),
    .ram_rdata_i  (ram_rdata)
  );

  data_ram_arbiter u_data_ram_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_req_i    (ram_req),
    .core_addr_i   (ram_addr),
    .core_we_i     (ram_we),
    .core_be_i     (ram_be),
    .core_wdata_i  (ram_wdata),
    .core_gnt_o    (ram_gnt),
    .core_rvalid_o (ram_rvalid),
    .core_rdata_o  (ram_rdata),
    .host_req_i    (host_req),
    .host_addr_i   (host_addr),
    .host_we_i     (host_we),
    .host_be_i     (host_be),
    .host_wdata_i  (host_wdata),
    .host_rdata_o  (host_rdata),
    .mem_en_o      (mem_en),
    .mem_addr_o    (mem_addr),
    .mem_we_o      (mem_we),
    .mem_be_o      (mem_be),
    .mem_wdata_o   (mem_wdata),
    .mem_rdata_i   (mem_rdata)
  );

  sp_data_ram #(
    .DEPTH (region_pkg::RAM_WORDS)
  ) u_sp_data_ram (
    .clk     (clk),
    .en_i    (mem_en),
    .addr_i  (mem_addr),
    .we_i    (mem_we),
    .be_i    (mem_be),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  apb_mem_port u_apb_mem_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .pstrb_i     (pstrb_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .mem_req_o   (host_req),
    .mem_addr_o  (host_addr),
    .mem_we_o    (host_we),
    .mem_be_o    (host_be),
    .mem_wdata_o (host_wdata),
    .mem_rdata_i (host_rdata)
  );

  irq_encoder u_irq_encoder (
    .irq_i    (irq_i),
    .irq_o    (irq_o),
    .irq_id_o (irq_id_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_core_region.sv ====
// testbench with clock, reset, random stimulus, external responder, model and watchdog
`default_nettype none

module tb_core_region;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned WINDOW_WORDS = 64;
  localparam int unsigned N_RANDOM     = 200;
  localparam int unsigned N_ALT        = 40;
  localparam int unsigned N_APB        = 40;
  localparam int unsigned N_CONC       = 30;
  localparam int unsigned N_IRQ        = 100;
  localparam int unsigned N_OPS        = WINDOW_WORDS + N_RANDOM + N_ALT + N_APB
                                         + 2 * N_CONC + N_IRQ;
  localparam int unsigned WATCHDOG_TIME = (N_OPS * 20 + RESET_CYCLES) * CLK_PERIOD;

  // local window sits in the region tag and the external one in the next tag
  localparam logic [31:0] LOCAL_BASE = {region_pkg::REGION_TAG, 20'h0};
  localparam logic [31:0] EXT_BASE   = {region_pkg::REGION_TAG + 12'h1, 20'h0};

  logic                              clk;
  logic                              rst_n;
  logic                              lsu_req_i;
  logic [region_pkg::ADDR_W-1:0]     lsu_addr_i;
  logic                              lsu_we_i;
  logic [region_pkg::BE_W-1:0]       lsu_be_i;
  logic [region_pkg::DATA_W-1:0]     lsu_wdata_i;
  logic                              lsu_gnt_o;
  logic                              lsu_rvalid_o;
  logic [region_pkg::DATA_W-1:0]     lsu_rdata_o;
  logic                              ext_req_o;
  logic [region_pkg::ADDR_W-1:0]     ext_addr_o;
  logic                              ext_we_o;
  logic [region_pkg::BE_W-1:0]       ext_be_o;
  logic [region_pkg::DATA_W-1:0]     ext_wdata_o;
  logic                              ext_gnt_i;
  logic                              ext_rvalid_i;
  logic [region_pkg::DATA_W-1:0]     ext_rdata_i;
  logic                              psel_i;
  logic                              penable_i;
  logic                              pwrite_i;
  logic [region_pkg::APB_ADDR_W-1:0] paddr_i;
  logic [region_pkg::DATA_W-1:0]     pwdata_i;
  logic [region_pkg::BE_W-1:0]       pstrb_i;
  logic [region_pkg::DATA_W-1:0]     prdata_o;
  logic                              pready_o;
  logic [region_pkg::IRQ_N-1:0]      irq_i;
  logic                              irq_o;
  logic [region_pkg::IRQ_ID_W-1:0]   irq_id_o;

  int unsigned error_count;
  int unsigned check_count;

  // word-indexed models of the local window and the external window
  logic [31:0] ram_model [int unsigned];
  logic [31:0] ext_model [int unsigned];

  core_region dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req_i),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_we_i     (lsu_we_i),
    .lsu_be_i     (lsu_be_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .lsu_gnt_o    (lsu_gnt_o),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .ext_req_o    (ext_req_o),
    .ext_addr_o   (ext_addr_o),
    .ext_we_o     (ext_we_o),
    .ext_be_o     (ext_be_o),
    .ext_wdata_o  (ext_wdata_o),
    .ext_gnt_i    (ext_gnt_i),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .pstrb_i      (pstrb_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .irq_i        (irq_i),
    .irq_o        (irq_o),
    .irq_id_o     (irq_id_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] stored_word(input int unsigned word);
    if (ram_model.exists(word)) begin
      return ram_model[word];
    end
    return 32'h0;
  endfunction

  // byte lanes with be set take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("Error %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic cond, input string what);
    check_count++;
    assert (cond) else begin
      error_count++;
      $display("Error %0t: %s", $time, what);
    end
  endtask

  // one LSU request held until gnt and then its single response
  task automatic lsu_access(input logic ext, input int unsigned word, input logic we,
                            input logic [3:0] be, input logic [31:0] wdata,
                            output int unsigned wait_cycles);
    logic [31:0] addr;
    logic [31:0] expected;
    logic        granted;
    addr        = (ext ? EXT_BASE : LOCAL_BASE) + 32'(word * 4);
    expected    = 32'h0;
    granted     = 1'b0;
    wait_cycles = 0;
    @(negedge clk);
    lsu_req_i   = 1'b1;
    lsu_addr_i  = addr;
    lsu_we_i    = we;
    lsu_be_i    = be;
    lsu_wdata_i = wdata;
    while (!granted) begin
      @(posedge clk);
      if (ext) begin
        check_flag(ext_req_o && ext_addr_o == addr && ext_we_o == we &&
                   ext_be_o == be && ext_wdata_o == wdata,
                   "external request does not match the LSU request");
        check_flag(lsu_gnt_o == ext_gnt_i, "LSU grant does not follow the external grant");
      end else begin
        check_flag(!ext_req_o, "local access appeared on the external port");
      end
      check_flag(!lsu_rvalid_o, "rvalid while the request waits for gnt");
      granted = lsu_gnt_o;
      if (!granted) begin
        wait_cycles++;
      end
    end
    if (ext) begin
      if (we) begin
        ext_model[word] = merge_bytes(ext_model[word], wdata, be);
      end else begin
        expected = ext_model[word];
      end
    end else if (we) begin
      ram_model[word] = merge_bytes(stored_word(word), wdata, be);
    end else begin
      expected = stored_word(word);
    end
    @(negedge clk);
    lsu_req_i = 1'b0;
    if (ext) begin
      do begin
        @(posedge clk);
        check_flag(lsu_rvalid_o == ext_rvalid_i, "rvalid not taken from the external port");
      end while (!lsu_rvalid_o);
      if (!we) begin
        check_word(lsu_rdata_o, expected, "external read data");
      end
    end else begin
      @(posedge clk);
      check_flag(lsu_rvalid_o, "local rvalid missing one cycle after gnt");
      if (!we) begin
        check_word(lsu_rdata_o, expected, "local read data");
      end
    end
  endtask

  task automatic apb_transfer(input logic we, input int unsigned word,
                              input logic [31:0] wdata, input logic [3:0] strb);
    logic [31:0] expected;
    int unsigned access_cycles;
    expected      = 32'h0;
    access_cycles = 0;
    @(negedge clk);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = we;
    paddr_i   = 15'(word * 4);
    pwdata_i  = wdata;
    pstrb_i   = strb;
    @(posedge clk);
    check_flag(!pready_o, "pready high in the APB setup phase");
    @(negedge clk);
    penable_i = 1'b1;
    do begin
      @(posedge clk);
      access_cycles++;
      // the RAM is accessed in the first access cycle
      if (access_cycles == 1) begin
        if (we) begin
          ram_model[word] = merge_bytes(stored_word(word), wdata, strb);
        end else begin
          expected = stored_word(word);
        end
      end
    end while (!pready_o);
    check_word(access_cycles, 32'd2, "APB access cycles up to pready");
    if (!we) begin
      check_word(prdata_o, expected, "APB read data");
    end
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  // external target granting after a random wait with read data from the model
  initial begin : ext_responder
    int unsigned delay;
    int unsigned latency;
    int unsigned word;
    logic [31:0] data;
    forever begin
      @(posedge clk);
      if (ext_req_o) begin
        delay = $urandom_range(0, 3);
        repeat (delay) @(posedge clk);
        @(negedge clk);
        ext_gnt_i = 1'b1;
        @(posedge clk);
        word = 32'(ext_addr_o[7:2]);
        data = ext_we_o ? $urandom() : ext_model[word];
        @(negedge clk);
        ext_gnt_i = 1'b0;
        latency = $urandom_range(1, 3);
        repeat (latency - 1) @(negedge clk);
        ext_rvalid_i = 1'b1;
        ext_rdata_i  = data;
        @(negedge clk);
        ext_rvalid_i = 1'b0;
        ext_rdata_i  = $urandom();
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    $display("timeout: the run did not finish in the expected time");
    $display("Testbench failed");
    $finish;
  end

  initial begin : stimulus
    int unsigned waits;
    int unsigned word;
    logic        ext;
    logic        we;
    logic [3:0]  be;
    logic [31:0] irq_vec;
    logic [4:0]  exp_id;
    logic        found;
    error_count = 0;
    check_count = 0;
    void'($urandom(32'h91097d32));
    clk          = 1'b0;
    rst_n        = 1'b0;
    lsu_req_i    = 1'b0;
    lsu_addr_i   = '0;
    lsu_we_i     = 1'b0;
    lsu_be_i     = '0;
    lsu_wdata_i  = '0;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    paddr_i      = '0;
    pwdata_i     = '0;
    pstrb_i      = '0;
    irq_i        = '0;
    for (int unsigned w = 0; w < WINDOW_WORDS; w++) begin
      ext_model[w] = $urandom();
    end
    repeat (RESET_CYCLES) @(posedge clk);
    check_flag(!lsu_gnt_o && !lsu_rvalid_o && !ext_req_o && !pready_o,
               "outputs not idle in reset");
    @(negedge clk);
    rst_n = 1'b1;

    // fill the local window over APB
    for (int unsigned w = 0; w < WINDOW_WORDS; w++) begin
      apb_transfer(1'b1, w, $urandom(), 4'hf);
    end

    // random local and external accesses
    for (int unsigned i = 0; i < N_RANDOM; i++) begin
      ext  = 1'($urandom_range(0, 1));
      we   = 1'($urandom_range(0, 1));
      be   = we ? 4'($urandom()) : 4'hf;
      word = $urandom_range(0, WINDOW_WORDS - 1);
      lsu_access(ext, word, we, be, $urandom(), waits);
      if (!ext) begin
        check_word(waits, 32'd0, "local LSU wait cycles with APB idle");
      end
    end

    // strict alternation between the two targets
    for (int unsigned i = 0; i < N_ALT; i++) begin
      we = ($urandom_range(0, 3) == 0);
      lsu_access(1'((i % 2) == 1), $urandom_range(0, WINDOW_WORDS - 1), we,
                 4'($urandom()), $urandom(), waits);
    end

    // APB reads see the words the LSU wrote
    for (int unsigned i = 0; i < N_APB; i++) begin
      apb_transfer(1'($urandom_range(0, 1)), $urandom_range(0, WINDOW_WORDS - 1),
                   $urandom(), 4'($urandom()));
    end

    // LSU request raised in the APB request cycle
    for (int unsigned i = 0; i < N_CONC; i++) begin
      we   = 1'($urandom_range(0, 1));
      word = $urandom_range(0, 7);
      fork
        apb_transfer(1'($urandom_range(0, 1)), $urandom_range(0, 7), $urandom(),
                     4'($urandom()));
        begin
          @(negedge clk);
          lsu_access(1'b0, word, we, 4'($urandom()), $urandom(), waits);
        end
      join
      check_word(waits, 32'd1, "LSU wait cycles behind an APB request");
    end

    // interrupt lines with none, one or many set
    for (int unsigned i = 0; i < N_IRQ; i++) begin
      case (i % 4)
        0:       irq_vec = 32'h0;
        1:       irq_vec = 32'h1 << $urandom_range(0, 31);
        default: irq_vec = $urandom();
      endcase
      exp_id = 5'd0;
      found  = 1'b0;
      for (int j = 31; j >= 0; j--) begin
        if (!found && irq_vec[j]) begin
          exp_id = 5'(j);
          found  = 1'b1;
        end
      end
      @(negedge clk);
      irq_i = irq_vec;
      @(posedge clk);
      check_flag(irq_o == (irq_vec != 32'h0), "irq flag does not match the lines");
      check_word(32'(irq_id_o), 32'(exp_id), "irq index");
    end

    @(negedge clk);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
source/region_pkg.sv
source/lsu_router.sv
source/data_ram_arbiter.sv
source/sp_data_ram.sv
source/apb_mem_port.sv
source/irq_encoder.sv
source/core_region.sv
testbench/tb_core_region.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_core_region
RTL_TOP    := core_region
FILELIST   := src.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint lint_rtl sim clean

all: sim

lint: lint_rtl
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

lint_rtl:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		source/region_pkg.sv source/lsu_router.sv source/data_ram_arbiter.sv \
		source/sp_data_ram.sv source/apb_mem_port.sv source/irq_encoder.sv \
		source/core_region.sv

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
